// ==== Bender.yml ====
package:
  name: ramtest

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/mem_pkg.sv
      - design/dma_pkg.sv
      - design/pipe_fifo.sv
      - design/dma_engine.sv
      - design/mem_port.sv
      - design/ramtest.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/ramtest_tb.sv

// ==== design/dma_engine.sv ====
//----------------------------------------------------------
// DMA engine
// Schedules fixed-size bursts between the pipe FIFOs and
// the word memory. Tracks write and read addresses and the
// number of words held in memory, so the memory behaves as
// one deep FIFO. Commands use a four-phase req/ack
//----------------------------------------------------------
`include "ramtest_macros.svh"

module dma_engine (
	input  logic                          okClk,
	input  logic                          rst_n,
	input  logic                          writes_en,
	input  logic                          reads_en,
	input  logic [`RAMTEST_FIFO_CNT_W-1:0] in_count,
	input  logic [`RAMTEST_FIFO_CNT_W-1:0] out_count,
	input  logic                          cmd_ack,
	output logic                          cmd_req,
	output mem_pkg::mem_op_t              cmd_op,
	output mem_pkg::mem_addr_t            cmd_addr
);

	import mem_pkg::*;
	import dma_pkg::*;

	localparam int STORED_W = $clog2(`RAMTEST_MEM_WORDS + 1);
	localparam logic [STORED_W-1:0] BURST_INC = STORED_W'(`RAMTEST_BURST_LEN);

	dma_state_t            state;
	mem_addr_t             wr_addr;
	mem_addr_t             rd_addr;
	logic [STORED_W-1:0]   stored;      // Written but not yet read back
	mem_op_t               op_q;
	logic                  last_write;  // Last burst went to memory
	logic                  can_write;
	logic                  can_read;

	// Start of the next burst, wraps at the memory end
	function automatic mem_addr_t next_addr(input mem_addr_t addr);
		return mem_addr_t'((addr + `RAMTEST_BURST_LEN) % `RAMTEST_MEM_WORDS);
	endfunction

	//----------------------------------------------------------
	// Burst eligibility
	//----------------------------------------------------------
	// Whole burst waiting and room in memory
	assign can_write = writes_en
		&& (in_count >= `RAMTEST_BURST_LEN)
		&& (stored + `RAMTEST_BURST_LEN <= `RAMTEST_MEM_WORDS);

	// Whole burst stored and room in the output FIFO
	assign can_read = reads_en
		&& (stored >= BURST_INC)
		&& (out_count <= `RAMTEST_FIFO_DEPTH - `RAMTEST_BURST_LEN);

	//----------------------------------------------------------
	// Command outputs
	//----------------------------------------------------------
	assign cmd_req = (state == DMA_WRITE_REQ) || (state == DMA_WRITE_WAIT)
		|| (state == DMA_READ_REQ) || (state == DMA_READ_WAIT);
	assign cmd_op   = op_q;
	assign cmd_addr = (op_q == MEM_OP_WRITE) ? wr_addr : rd_addr;

	//----------------------------------------------------------
	// Scheduler
	//----------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			state      <= DMA_IDLE;
			wr_addr    <= '0;
			rd_addr    <= '0;
			stored     <= '0;
			op_q       <= MEM_OP_WRITE;
			last_write <= 1'b0;
		end else begin
			case (state)
				DMA_IDLE: begin
					// Writes win a tie unless the last burst was a write
					if (can_write && (!can_read || !last_write)) begin
						op_q       <= MEM_OP_WRITE;
						last_write <= 1'b1;
						state      <= DMA_WRITE_REQ;
					end else if (can_read) begin
						op_q       <= MEM_OP_READ;
						last_write <= 1'b0;
						state      <= DMA_READ_REQ;
					end
				end
				DMA_WRITE_REQ: state <= DMA_WRITE_WAIT;
				DMA_WRITE_WAIT: begin
					if (cmd_ack) begin
						wr_addr <= next_addr(wr_addr);
						stored  <= stored + BURST_INC;
						state   <= DMA_RELEASE;
					end
				end
				DMA_READ_REQ: state <= DMA_READ_WAIT;
				DMA_READ_WAIT: begin
					if (cmd_ack) begin
						rd_addr <= next_addr(rd_addr);
						stored  <= stored - BURST_INC;
						state   <= DMA_RELEASE;
					end
				end
				DMA_RELEASE: begin
					if (!cmd_ack)
						state <= DMA_IDLE;  // Handshake back to rest
				end
				default: state <= DMA_IDLE;
			endcase
		end
	end

	// The port uses opcode and address for the whole burst
	a_cmd_stable: assert property (@(posedge okClk) disable iff (!rst_n)
		cmd_req && $past(cmd_req) |-> $stable(cmd_op) && $stable(cmd_addr));

endmodule

// ==== design/dma_pkg.sv ====
//----------------------------------------------------------
// DMA engine types
// State encoding of the burst scheduler
//----------------------------------------------------------

package dma_pkg;

	// Scheduler states
	typedef enum logic [2:0] {
		DMA_IDLE       = 3'd0,  // Pick the next burst
		DMA_WRITE_REQ  = 3'd1,
		DMA_WRITE_WAIT = 3'd2,
		DMA_READ_REQ   = 3'd3,
		DMA_READ_WAIT  = 3'd4,
		DMA_RELEASE    = 3'd5   // Waiting for ack to drop
	} dma_state_t;

endpackage

// ==== design/mem_pkg.sv ====
//----------------------------------------------------------
// Memory port types
// Command opcode and word address carried on the
// command path between the DMA engine and the memory port
//----------------------------------------------------------
`include "ramtest_macros.svh"

package mem_pkg;

	//----------------------------------------------------------
	// Command opcode
	//----------------------------------------------------------
	typedef enum logic {
		MEM_OP_WRITE = 1'b0,  // Input FIFO to memory
		MEM_OP_READ  = 1'b1   // Memory to output FIFO
	} mem_op_t;

	//----------------------------------------------------------
	// Word address
	//----------------------------------------------------------
	// Points at the first word of a burst
	typedef logic [`RAMTEST_MEM_ADDR_W-1:0] mem_addr_t;

endpackage

// ==== design/mem_port.sv ====
//----------------------------------------------------------
// Memory port
// Word memory behind a four-phase command port. A write
// command pops a burst from the input FIFO into memory,
// a read command pushes a burst into the output FIFO.
// The burst runs without stalls
//----------------------------------------------------------
`include "ramtest_macros.svh"

module mem_port (
	input  logic                       okClk,
	input  logic                       rst_n,
	input  logic                       cmd_req,
	input  mem_pkg::mem_op_t           cmd_op,
	input  mem_pkg::mem_addr_t         cmd_addr,
	input  logic [`RAMTEST_DATA_W-1:0] in_data,
	output logic                       cmd_ack,
	output logic                       in_pop,
	output logic                       out_push,
	output logic [`RAMTEST_DATA_W-1:0] out_data
);

	import mem_pkg::*;

	localparam int BEAT_W = $clog2(`RAMTEST_BURST_LEN);
	localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`RAMTEST_BURST_LEN - 1);

	logic [`RAMTEST_DATA_W-1:0] mem [`RAMTEST_MEM_WORDS];
	logic                       active;      // Burst data phase
	logic [BEAT_W-1:0]          beat;
	logic                       start;
	logic                       rd_fetch;
	logic [BEAT_W-1:0]          fetch_beat;
	mem_addr_t                  wr_word;
	mem_addr_t                  rd_word;

	// New command only once the previous ack has dropped
	assign start = cmd_req && !active && !cmd_ack;

	// Write side pops the FIFO head on every beat
	assign in_pop  = active && (cmd_op == MEM_OP_WRITE);
	assign wr_word = cmd_addr + mem_addr_t'(beat);

	// Read side fetches one beat ahead of the push
	assign fetch_beat = start ? '0 : beat + 1'b1;
	assign rd_fetch   = (cmd_op == MEM_OP_READ)
		&& (start || (active && (beat != LAST_BEAT)));
	assign rd_word    = cmd_addr + mem_addr_t'(fetch_beat);

	//----------------------------------------------------------
	// Word array
	//----------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (in_pop)
			mem[wr_word] <= in_data;
		if (rd_fetch)
			out_data <= mem[rd_word];
	end

	//----------------------------------------------------------
	// Burst counter and handshake
	//----------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			active   <= 1'b0;
			beat     <= '0;
			cmd_ack  <= 1'b0;
			out_push <= 1'b0;
		end else begin
			out_push <= rd_fetch;  // Lines up with out_data
			if (start) begin
				active <= 1'b1;
				beat   <= '0;
			end else if (active) begin
				beat <= beat + 1'b1;
				if (beat == LAST_BEAT) begin
					active  <= 1'b0;
					cmd_ack <= 1'b1;
				end
			end else if (cmd_ack && !cmd_req) begin
				cmd_ack <= 1'b0;   // Last phase of the handshake
			end
		end
	end

	// Ack only answers a request, and outlives it by one cycle
	a_ack_after_req: assert property (@(posedge okClk) disable iff (!rst_n)
		cmd_ack |-> cmd_req || $past(cmd_req));

endmodule

// ==== design/pipe_fifo.sv ====
//----------------------------------------------------------
// Pipe FIFO
// Single-clock first-word-fall-through buffer with an
// occupancy count and registered block-throttle flags
//   space_ok  room for one more host block
//   block_ok  at least one whole block stored
//----------------------------------------------------------
`include "ramtest_macros.svh"

module pipe_fifo #(
	parameter int DEPTH = `RAMTEST_FIFO_DEPTH,
	parameter int BLOCK = `RAMTEST_BLOCK_SIZE
) (
	input  logic                       okClk,
	input  logic                       rst_n,
	input  logic                       push,
	input  logic [`RAMTEST_DATA_W-1:0] push_data,
	input  logic                       pop,
	output logic [`RAMTEST_DATA_W-1:0] head_data,
	output logic                       empty,
	output logic                       full,
	output logic [$clog2(DEPTH+1)-1:0] count,
	output logic                       space_ok,
	output logic                       block_ok
);

	localparam int PTR_W     = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W     = $clog2(DEPTH + 1);
	localparam int SPACE_MAX = DEPTH - `RAMTEST_HEADROOM - BLOCK;

	logic [`RAMTEST_DATA_W-1:0] buf_q [DEPTH];
	logic [PTR_W-1:0]           wr_ptr;
	logic [PTR_W-1:0]           rd_ptr;
	logic [CNT_W-1:0]           count_q;
	logic                       do_push;
	logic                       do_pop;

	assign empty   = (count_q == '0);
	assign full    = (count_q == CNT_W'(DEPTH));
	assign count   = count_q;
	assign do_push = push && !full;   // Overflow push is dropped
	assign do_pop  = pop && !empty;

	// Head word shows before the pop
	assign head_data = buf_q[rd_ptr];

	always_ff @(posedge okClk) begin
		if (do_push)
			buf_q[wr_ptr] <= push_data;
	end

	//----------------------------------------------------------
	// Pointers and occupancy
	//----------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_q <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// Block throttle, one cycle behind the count
	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			space_ok <= 1'b0;
			block_ok <= 1'b0;
		end else begin
			space_ok <= (count_q <= SPACE_MAX);
			block_ok <= (count_q >= BLOCK);
		end
	end

	// The host and the memory port rely on the flags
	a_no_overflow: assert property (@(posedge okClk) disable iff (!rst_n)
		push |-> !full);
	a_no_underflow: assert property (@(posedge okClk) disable iff (!rst_n)
		pop |-> !empty);

endmodule

// ==== design/ramtest.sv ====
//----------------------------------------------------------
// RAM test loopback top
// Host words enter the input pipe FIFO, move to the word
// memory in bursts and come back through the output pipe
// FIFO in the same order
//----------------------------------------------------------
`include "ramtest_macros.svh"

module ramtest (
	input  logic                       okClk,
	input  logic                       rst_n,
	input  logic                       writes_en,
	input  logic                       reads_en,
	input  logic                       pipe_in_write,
	input  logic [`RAMTEST_DATA_W-1:0] pipe_in_data,
	input  logic                       pipe_out_read,
	output logic                       pipe_in_ready,
	output logic                       pipe_in_full,
	output logic [`RAMTEST_DATA_W-1:0] pipe_out_data,
	output logic                       pipe_out_ready,
	output logic                       pipe_out_empty
);

	import mem_pkg::*;

	logic [`RAMTEST_FIFO_CNT_W-1:0] in_count;
	logic [`RAMTEST_FIFO_CNT_W-1:0] out_count;
	logic [`RAMTEST_DATA_W-1:0]     in_head;
	logic [`RAMTEST_DATA_W-1:0]     out_data;
	logic                           in_pop;
	logic                           out_push;
	logic                           cmd_req;
	logic                           cmd_ack;
	mem_op_t                        cmd_op;
	mem_addr_t                      cmd_addr;

	// Host to memory
	pipe_fifo in_fifo (
		.okClk(okClk), .rst_n(rst_n),
		.push(pipe_in_write), .push_data(pipe_in_data), .pop(in_pop),
		.head_data(in_head), .empty(), .full(pipe_in_full), .count(in_count),
		.space_ok(pipe_in_ready), .block_ok()
	);

	dma_engine dma_i (
		.okClk(okClk), .rst_n(rst_n),
		.writes_en(writes_en), .reads_en(reads_en),
		.in_count(in_count), .out_count(out_count),
		.cmd_ack(cmd_ack), .cmd_req(cmd_req), .cmd_op(cmd_op), .cmd_addr(cmd_addr)
	);

	mem_port mem_i (
		.okClk(okClk), .rst_n(rst_n),
		.cmd_req(cmd_req), .cmd_op(cmd_op), .cmd_addr(cmd_addr), .in_data(in_head),
		.cmd_ack(cmd_ack), .in_pop(in_pop), .out_push(out_push), .out_data(out_data)
	);

	// Memory to host
	pipe_fifo out_fifo (
		.okClk(okClk), .rst_n(rst_n),
		.push(out_push), .push_data(out_data), .pop(pipe_out_read),
		.head_data(pipe_out_data), .empty(pipe_out_empty), .full(), .count(out_count),
		.space_ok(), .block_ok(pipe_out_ready)
	);

endmodule

// ==== include/ramtest_macros.svh ====
//----------------------------------------------------------
// RAM test loopback constants
// Widths, FIFO sizing, host block and memory burst sizes
// shared by the packages and the RTL
//----------------------------------------------------------
`ifndef RAMTEST_MACROS_SVH
`define RAMTEST_MACROS_SVH

// Data path
`define RAMTEST_DATA_W      32

// Pipe FIFOs
`define RAMTEST_FIFO_DEPTH  256
`define RAMTEST_FIFO_CNT_W  9   // Holds 0 to 256

// Host block throttle
`define RAMTEST_BLOCK_SIZE  64
`define RAMTEST_HEADROOM    4   // Margin for the late flag update

// Memory side
`define RAMTEST_BURST_LEN   16  // Words per command
`define RAMTEST_MEM_WORDS   512
`define RAMTEST_MEM_ADDR_W  9

// Burst must divide the memory so that
// bursts never straddle the address wrap

`endif

// ==== ramtest.f ====
+incdir+include
design/mem_pkg.sv
design/dma_pkg.sv
design/pipe_fifo.sv
design/dma_engine.sv
design/mem_port.sv
design/ramtest.sv
test/ramtest_tb.sv

// ==== test/ramtest_tb.sv ====
//----------------------------------------------------------
// RAM test loopback testbench
// Directed tests push host blocks through the DUT and
// compare the returned words with a reference queue
//----------------------------------------------------------
`include "ramtest_macros.svh"

module ramtest_tb;

	localparam int DRIVE_DLY  = 10;
	localparam int BLOCK      = `RAMTEST_BLOCK_SIZE;
	localparam int SPACE_MAX  = 188;    // Highest count that still admits a block
	localparam int WAIT_LIMIT = 2000;   // Cycles per wait loop

	logic                       okClk;
	logic                       rst_n;
	logic                       writes_en;
	logic                       reads_en;
	logic                       pipe_in_write;
	logic [`RAMTEST_DATA_W-1:0] pipe_in_data;
	logic                       pipe_out_read;
	logic                       pipe_in_ready;
	logic                       pipe_in_full;
	logic [`RAMTEST_DATA_W-1:0] pipe_out_data;
	logic                       pipe_out_ready;
	logic                       pipe_out_empty;

	logic [`RAMTEST_DATA_W-1:0] ref_q [$];   // Words pushed but not yet popped
	integer                     seed;
	int                         errors;

	ramtest ramtest_i (
		.okClk(okClk), .rst_n(rst_n),
		.writes_en(writes_en), .reads_en(reads_en),
		.pipe_in_write(pipe_in_write), .pipe_in_data(pipe_in_data),
		.pipe_out_read(pipe_out_read),
		.pipe_in_ready(pipe_in_ready), .pipe_in_full(pipe_in_full),
		.pipe_out_data(pipe_out_data), .pipe_out_ready(pipe_out_ready),
		.pipe_out_empty(pipe_out_empty)
	);

	initial begin
		okClk = 1'b0;
		forever #50 okClk = ~okClk;
	end

	//----------------------------------------------------------
	// Helpers
	//----------------------------------------------------------
	// Drive point shortly after the rising edge
	task automatic next_cycle();
		@(posedge okClk);
		#DRIVE_DLY;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			errors++;
			$display("ERROR at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("Failure at %0t: %s", $time, msg);
	endtask

	// One random word for one cycle
	task automatic push_word();
		logic [31:0] data;
		data = $random(seed);
		pipe_in_write = 1'b1;
		pipe_in_data  = data;
		ref_q.push_back(data);
		next_cycle();
		pipe_in_write = 1'b0;
	endtask

	task automatic push_block();
		int waited;
		int i;
		waited = 0;
		next_cycle();   // Flag catches up with the last push
		while (!pipe_in_ready && waited < WAIT_LIMIT) begin
			next_cycle();
			waited++;
		end
		if (!pipe_in_ready) begin
			report_failure("pipe_in_ready never rose, block not pushed");
			return;
		end
		for (i = 0; i < BLOCK; i++)
			push_word();
	endtask

	task automatic pop_block();
		int waited;
		int i;
		logic [31:0] expected;
		waited = 0;
		next_cycle();
		while (!pipe_out_ready && waited < WAIT_LIMIT) begin
			next_cycle();
			waited++;
		end
		if (!pipe_out_ready) begin
			report_failure("pipe_out_ready never rose, no block to read");
			return;
		end
		for (i = 0; i < BLOCK; i++) begin
			check_value("pipe_out_empty", 1'b0, pipe_out_empty);
			if (pipe_out_empty) begin
				pipe_out_read = 1'b0;
				return;
			end
			expected = ref_q.pop_front();
			check_value("pipe_out_data", expected, pipe_out_data);
			pipe_out_read = 1'b1;   // Head advances at the next edge
			next_cycle();
		end
		pipe_out_read = 1'b0;
	endtask

	// Read back everything still owed
	task automatic drain();
		int blocks;
		blocks = (ref_q.size() + BLOCK - 1) / BLOCK;
		repeat (blocks) pop_block();
		assert (ref_q.size() == 0) else
			report_failure("Pushed words never came back at the output");
		check_value("pipe_out_empty", 1'b1, pipe_out_empty);
	endtask

	task automatic expect_output_idle(input int cycles);
		repeat (cycles) begin
			next_cycle();
			check_value("pipe_out_empty", 1'b1, pipe_out_empty);
		end
	endtask

	//----------------------------------------------------------
	// Directed tests
	//----------------------------------------------------------
	task automatic test_reset();
		int waited;
		check_value("pipe_out_empty", 1'b1, pipe_out_empty);
		check_value("pipe_out_ready", 1'b0, pipe_out_ready);
		check_value("pipe_in_ready", 1'b0, pipe_in_ready);
		waited = 0;
		while (!pipe_in_ready && waited < 4) begin
			next_cycle();
			waited++;
		end
		assert (pipe_in_ready) else
			report_failure("pipe_in_ready did not rise after reset");
	endtask

	task automatic test_single_block();
		writes_en = 1'b1;
		reads_en  = 1'b1;
		push_block();
		pop_block();
		check_value("pipe_out_empty", 1'b1, pipe_out_empty);
	endtask

	task automatic test_writes_disabled();
		writes_en = 1'b0;
		reads_en  = 1'b1;
		push_block();
		push_block();
		expect_output_idle(200);   // Words held in the input FIFO
		writes_en = 1'b1;
		drain();
	endtask

	task automatic test_reads_disabled();
		writes_en = 1'b1;
		reads_en  = 1'b0;
		repeat (6) push_block();
		expect_output_idle(600);
		reads_en = 1'b1;
		drain();   // Read address wraps the memory here
	endtask

	task automatic test_input_throttle();
		int n;
		int waited;
		writes_en = 1'b0;
		reads_en  = 1'b1;
		next_cycle();
		n = 0;
		// Flag reflects the count one cycle late
		while (n <= SPACE_MAX) begin
			check_value("pipe_in_ready", 1'b1, pipe_in_ready);
			push_word();
			n++;
			next_cycle();
		end
		check_value("pipe_in_ready", 1'b0, pipe_in_ready);
		check_value("pipe_in_full", 1'b0, pipe_in_full);
		repeat (16) begin
			next_cycle();
			check_value("pipe_in_ready", 1'b0, pipe_in_ready);
		end
		writes_en = 1'b1;
		waited = 0;
		while (!pipe_in_ready && waited < WAIT_LIMIT) begin
			next_cycle();
			waited++;
		end
		assert (pipe_in_ready) else
			report_failure("pipe_in_ready stayed low after writes were enabled");
		// Top up to whole blocks
		while (ref_q.size() % BLOCK != 0) begin
			check_value("pipe_in_ready", 1'b1, pipe_in_ready);
			push_word();
		end
		drain();
	endtask

	//----------------------------------------------------------
	// Main sequence
	//----------------------------------------------------------
	initial begin
		seed          = 32'hc1ae_ace7;
		errors        = 0;
		rst_n         = 1'b0;
		writes_en     = 1'b0;
		reads_en      = 1'b0;
		pipe_in_write = 1'b0;
		pipe_in_data  = '0;
		pipe_out_read = 1'b0;
		repeat (8) @(posedge okClk);
		#DRIVE_DLY;
		rst_n = 1'b1;

		test_reset();
		test_single_block();
		test_writes_disabled();
		test_reads_disabled();
		test_input_throttle();

		$display("Run complete, error count %0d", errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
